// File: Bender.yml
package:
  name: rvfi_tracer

sources:
  - logic/isa_pkg.sv
  - logic/trace_pkg.sv
  - logic/issue_latch.sv
  - logic/trans_table.sv
  - logic/amo_wdata_calc.sv
  - logic/retire_ctrl.sv
  - logic/rvfi_tracer.sv
  - target: simulation
    files:
      - dv/rvfi_tracer_chk.sv
      - dv/tb_rvfi_tracer.sv

// File: dv/retire_input.txt
# name instr c id rs1 rs2 lsu be addr sdata op old exv cause drop flush, then expected
# valid trap insn rmask wmask mem_wdata; hex, lsu 0/1/2 none/load/store, op is commit_op_e
alu 00c58533 0 0 11111111 22222222 0 0 0 0 0 33333333 0 0 0 0 1 0 00c58533 0 0 0
alui 02a30313 0 1 00000064 0 0 0 0 0 0 0000008e 0 0 0 0 1 0 02a30313 0 0 0
rvc e7c9a6b5 1 2 5 6 0 0 0 0 0 b 0 0 0 0 1 0 a6b5 0 0 0
rvc2 00004501 1 3 0 0 0 0 0 0 0 0 0 0 0 0 1 0 4501 0 0 0
lw 0002a503 0 4 80001000 0 1 f 80001000 0 1 deadbeef 0 0 0 0 1 0 0002a503 f 0 0
lbu 0062c583 0 5 80001000 0 1 4 80001006 0 1 000000be 0 0 0 0 1 0 0062c583 4 0 0
sw 00b2a023 0 6 80002000 cafef00d 2 f 80002000 cafef00d 2 0 0 0 0 0 1 0 00b2a023 0 f cafef00d
sh 00b29023 0 7 80002000 0000beef 2 3 80002000 0000beef 2 0 0 0 0 0 1 0 00b29023 0 3 0000beef
nobe 0002a503 0 0 80001000 0 1 0 80001000 0 1 0 0 0 0 0 1 0 0002a503 0 0 0
sc 18c5a52f 0 1 80003000 12345678 0 0 0 0 3 0 0 0 0 0 1 0 18c5a52f 0 0 12345678
swap 08c5a52f 0 2 80003000 aaaa5555 0 0 0 0 4 11110000 0 0 0 0 1 0 08c5a52f 0 0 aaaa5555
add 00c5a52f 0 3 80003000 ffffffff 0 0 0 0 5 00000002 0 0 0 0 1 0 00c5a52f 0 0 00000001
add2 00c5a52f 0 4 80003000 7fffffff 0 0 0 0 5 00000001 0 0 0 0 1 0 00c5a52f 0 0 80000000
and 60c5a52f 0 5 80003000 ff00ff00 0 0 0 0 6 f0f0f0f0 0 0 0 0 1 0 60c5a52f 0 0 f000f000
or 40c5a52f 0 6 80003000 0f0f0000 0 0 0 0 7 f0f0f0f0 0 0 0 0 1 0 40c5a52f 0 0 fffff0f0
xor 20c5a52f 0 7 80003000 0ff00ff0 0 0 0 0 8 ffff0000 0 0 0 0 1 0 20c5a52f 0 0 f00f0ff0
max a0c5a52f 0 0 80003000 7fffffff 0 0 0 0 9 80000000 0 0 0 0 1 0 a0c5a52f 0 0 7fffffff
max2 a0c5a52f 0 1 80003000 fffffffb 0 0 0 0 9 00000005 0 0 0 0 1 0 a0c5a52f 0 0 00000005
min 80c5a52f 0 2 80003000 7fffffff 0 0 0 0 a 80000000 0 0 0 0 1 0 80c5a52f 0 0 80000000
min2 80c5a52f 0 3 80003000 fffffffd 0 0 0 0 a fffffffe 0 0 0 0 1 0 80c5a52f 0 0 fffffffd
maxu e0c5a52f 0 4 80003000 7fffffff 0 0 0 0 b 80000000 0 0 0 0 1 0 e0c5a52f 0 0 80000000
minu c0c5a52f 0 5 80003000 7fffffff 0 0 0 0 c 80000000 0 0 0 0 1 0 c0c5a52f 0 0 7fffffff
minueq c0c5a52f 0 6 80003000 00000010 0 0 0 0 c 00000010 0 0 0 0 1 0 c0c5a52f 0 0 00000010
ecallm 00000073 0 4 0 0 0 0 0 0 0 0 1 b 0 0 1 1 00000073 0 0 0
ecallu 00000073 0 5 0 0 0 0 0 0 0 0 1 8 0 0 1 1 00000073 0 0 0
ecalls 00000073 0 6 0 0 0 0 0 0 0 0 1 9 0 0 1 1 00000073 0 0 0
illegal ffffffff 0 6 0 0 0 0 0 0 0 0 1 2 0 0 0 1 ffffffff 0 0 0
ldfault 0002a503 0 7 80001000 0 1 f 80001000 0 1 0 1 5 0 0 0 1 0002a503 f 0 0
irq 00c58533 0 0 1 2 0 0 0 0 0 0 1 80000007 0 0 0 0 00c58533 0 0 0
drop 00c58533 0 1 1 2 0 0 0 0 0 5 0 0 1 0 0 0 00c58533 0 0 0
dropex 00000073 0 2 0 0 0 0 0 0 0 0 1 b 1 0 0 0 00000073 0 0 0
flushst 00b2a023 0 3 80002000 cafef00d 2 f 80002000 cafef00d 2 0 0 0 0 1 1 0 0 0 0 0
flushld 0002a503 0 4 80001000 0 1 f 80001000 0 1 0 0 0 0 1 1 0 0 0 0 0
after 00c58533 0 3 11111111 22222222 0 0 0 0 0 0 0 0 0 0 1 0 00c58533 0 0 0

// File: dv/rvfi_tracer_chk.sv
// Retirement record assertions

module rvfi_tracer_chk #(
  parameter int unsigned Xlen = 32
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              commit_valid_i,
  input logic              commit_drop_i,
  input logic              ex_valid_i,
  input logic              rvfi_valid_o,
  input logic              rvfi_trap_o,
  input logic [Xlen/8-1:0] rvfi_mem_rmask_o,
  input logic [Xlen/8-1:0] rvfi_mem_wmask_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned err_count = 0;
  logic        exception;

  assign exception = commit_valid_i && ex_valid_i && !commit_drop_i;

  // A trap always follows an exception at commit
  trap_needs_exception: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_trap_o |-> $past(exception))
    else begin
      err_count++;
      $error("trap reported without an exception in the cycle before");
    end

  valid_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !rvfi_valid_o)
    else begin
      err_count++;
      $error("valid is high in the cycle after reset");
    end

  masks_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((|rvfi_mem_rmask_o) && (|rvfi_mem_wmask_o)))
    else begin
      err_count++;
      $error("read mask and write mask are both nonzero");
    end

endmodule

bind rvfi_tracer rvfi_tracer_chk #(
  .Xlen (Xlen)
) u_chk (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .commit_valid_i   (commit_valid_i),
  .commit_drop_i    (commit_drop_i),
  .ex_valid_i       (ex_valid_i),
  .rvfi_valid_o     (rvfi_valid_o),
  .rvfi_trap_o      (rvfi_trap_o),
  .rvfi_mem_rmask_o (rvfi_mem_rmask_o),
  .rvfi_mem_wmask_o (rvfi_mem_wmask_o)
);

// File: dv/tb_rvfi_tracer.sv
// Tracer testbench

module tb_rvfi_tracer
  import isa_pkg::*;
  import trace_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Xlen        = DefaultXlen;
  localparam int unsigned NrSbEntries = DefaultSbEntries;
  localparam int unsigned TransIdW    = $clog2(NrSbEntries);
  localparam string       InputFile   = "dv/retire_input.txt";

  // --------------------------------------------------------------------------
  // DUT signals
  // --------------------------------------------------------------------------

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 fetch_valid_i;
  instr_t               fetch_instr_i;
  logic                 fetch_compressed_i;
  logic                 issue_ack_i;
  logic                 decoded_valid_i;
  logic                 decoded_ack_i;
  logic                 flush_unissued_i;
  logic [TransIdW-1:0]  issue_ptr_i;
  logic [Xlen-1:0]      rs1_rdata_i;
  logic [Xlen-1:0]      rs2_rdata_i;
  lsu_fu_e              lsu_fu_i;
  logic [Xlen/8-1:0]    lsu_be_i;
  logic [Xlen-1:0]      lsu_vaddr_i;
  logic [TransIdW-1:0]  lsu_trans_id_i;
  logic [Xlen-1:0]      store_wdata_i;
  logic                 commit_valid_i;
  logic                 commit_ack_i;
  logic                 commit_drop_i;
  logic [TransIdW-1:0]  commit_ptr_i;
  logic [Xlen-1:0]      commit_pc_i;
  commit_op_e           commit_op_i;
  reg_addr_t            commit_rs1_i;
  reg_addr_t            commit_rs2_i;
  reg_addr_t            commit_rd_i;
  logic [Xlen-1:0]      commit_wdata_i;
  logic [Xlen-1:0]      commit_result_i;
  logic                 ex_valid_i;
  logic [Xlen-1:0]      ex_cause_i;
  priv_lvl_e            priv_lvl_i;
  logic                 rvfi_valid_o;
  logic                 rvfi_trap_o;
  logic [Xlen-1:0]      rvfi_cause_o;
  logic [ModeWidth-1:0] rvfi_mode_o;
  instr_t               rvfi_insn_o;
  logic [Xlen-1:0]      rvfi_pc_o;
  reg_addr_t            rvfi_rs1_addr_o;
  reg_addr_t            rvfi_rs2_addr_o;
  reg_addr_t            rvfi_rd_addr_o;
  logic [Xlen-1:0]      rvfi_rs1_rdata_o;
  logic [Xlen-1:0]      rvfi_rs2_rdata_o;
  logic [Xlen-1:0]      rvfi_rd_wdata_o;
  logic [Xlen-1:0]      rvfi_mem_addr_o;
  logic [Xlen/8-1:0]    rvfi_mem_rmask_o;
  logic [Xlen/8-1:0]    rvfi_mem_wmask_o;
  logic [Xlen-1:0]      rvfi_mem_wdata_o;
  logic [Xlen-1:0]      rvfi_mem_rdata_o;

  // Current transaction, one data file line
  string               t_name;
  instr_t              t_instr;
  logic                t_comp;
  logic [TransIdW-1:0] t_id;
  logic [Xlen-1:0]     t_rs1;
  logic [Xlen-1:0]     t_rs2;
  logic [1:0]          t_lsu;
  logic [Xlen/8-1:0]   t_be;
  logic [Xlen-1:0]     t_addr;
  logic [Xlen-1:0]     t_sdata;
  logic [3:0]          t_op;
  logic [Xlen-1:0]     t_old;   // Old memory value, also the rd write data
  logic                t_exv;
  logic [Xlen-1:0]     t_cause;
  logic                t_drop;
  logic                t_flush;
  logic                e_valid;
  logic                e_trap;
  instr_t              e_insn;
  logic [Xlen/8-1:0]   e_rmask;
  logic [Xlen/8-1:0]   e_wmask;
  logic [Xlen-1:0]     e_mwdata;

  // Commit-side values that are only echoed
  logic [Xlen-1:0] r_pc;
  logic [Xlen-1:0] r_result;
  reg_addr_t       r_rs1;
  reg_addr_t       r_rs2;
  reg_addr_t       r_rd;
  priv_lvl_e       r_priv;

  integer      seed        = 32'ha3980e21;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 50;
  string       lines[$];
  string       line;
  int          fd;

  rvfi_tracer uut (.*);

  always #2 clk_i = ~clk_i; // 4 ns period

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic idle_inputs();
    flush_i            = 1'b0;
    fetch_valid_i      = 1'b0;
    fetch_instr_i      = '0;
    fetch_compressed_i = 1'b0;
    issue_ack_i        = 1'b0;
    decoded_valid_i    = 1'b0;
    decoded_ack_i      = 1'b0;
    flush_unissued_i   = 1'b0;
    issue_ptr_i        = '0;
    rs1_rdata_i        = '0;
    rs2_rdata_i        = '0;
    lsu_fu_i           = LSU_NONE;
    lsu_be_i           = '0;
    lsu_vaddr_i        = '0;
    lsu_trans_id_i     = '0;
    store_wdata_i      = '0;
    commit_valid_i     = 1'b0;
    commit_ack_i       = 1'b0;
    commit_drop_i      = 1'b0;
    commit_ptr_i       = '0;
    commit_pc_i        = '0;
    commit_op_i        = OP_OTHER;
    commit_rs1_i       = '0;
    commit_rs2_i       = '0;
    commit_rd_i        = '0;
    commit_wdata_i     = '0;
    commit_result_i    = '0;
    ex_valid_i         = 1'b0;
    ex_cause_i         = '0;
    priv_lvl_i         = PRIV_LVL_M;
  endtask

  function automatic bit parse_line(input string text);
    return $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                   t_name, t_instr, t_comp, t_id, t_rs1, t_rs2, t_lsu, t_be, t_addr,
                   t_sdata, t_op, t_old, t_exv, t_cause, t_drop, t_flush, e_valid,
                   e_trap, e_insn, e_rmask, e_wmask, e_mwdata) == 22;
  endfunction

  task automatic check_field(input string field, input logic [Xlen-1:0] exp_val,
                             input logic [Xlen-1:0] act_val);
    assert (act_val === exp_val) else begin
      $display("mismatch in %s, %s: expected %0h, actual %0h", t_name, field, exp_val,
               act_val);
      abort_run();
    end
  endtask

  // Fetch, issue, LSU and commit each take one cycle
  task automatic run_transaction();
    logic [31:0] rnd;
    r_pc     = $random(seed);
    r_pc[0]  = 1'b0;
    r_result = $random(seed);
    rnd      = $random(seed);
    r_rs1    = rnd[4:0];
    r_rs2    = rnd[9:5];
    r_rd     = rnd[14:10];
    case (rnd[16:15])
      2'd0:    r_priv = PRIV_LVL_U;
      2'd1:    r_priv = PRIV_LVL_S;
      default: r_priv = PRIV_LVL_M;
    endcase
    @(negedge clk_i);
    idle_inputs();
    fetch_valid_i      = 1'b1;
    fetch_instr_i      = t_instr;
    fetch_compressed_i = t_comp;
    @(negedge clk_i);
    idle_inputs();
    decoded_valid_i = 1'b1;
    decoded_ack_i   = 1'b1;
    issue_ack_i     = 1'b1;
    issue_ptr_i     = t_id;
    rs1_rdata_i     = t_rs1;
    rs2_rdata_i     = t_rs2;
    @(negedge clk_i);
    idle_inputs();
    lsu_fu_i       = lsu_fu_e'(t_lsu);
    lsu_be_i       = t_be;
    lsu_vaddr_i    = t_addr;
    lsu_trans_id_i = t_id;
    store_wdata_i  = t_sdata;
    if (t_flush) begin
      @(negedge clk_i);
      idle_inputs();
      flush_i = 1'b1; // Wipes both tables before the commit
    end
    @(negedge clk_i);
    idle_inputs();
    commit_valid_i  = 1'b1;
    commit_ack_i    = 1'b1;
    commit_drop_i   = t_drop;
    commit_ptr_i    = t_id;
    commit_pc_i     = r_pc;
    commit_op_i     = commit_op_e'(t_op);
    commit_rs1_i    = r_rs1;
    commit_rs2_i    = r_rs2;
    commit_rd_i     = r_rd;
    commit_wdata_i  = t_old;
    commit_result_i = r_result;
    ex_valid_i      = t_exv;
    ex_cause_i      = t_cause;
    priv_lvl_i      = r_priv;
    @(negedge clk_i); // Record registered at the edge in between
    idle_inputs();
  endtask

  task automatic check_record();
    logic [Xlen-1:0] exp_rs1;
    logic [Xlen-1:0] exp_rs2;
    logic [Xlen-1:0] exp_addr;
    exp_rs1  = t_flush ? '0 : t_rs1;
    exp_rs2  = t_flush ? '0 : t_rs2;
    // Only a load or store with some byte enabled leaves an address
    exp_addr = (!t_flush && (t_lsu != 2'd0) && (t_be != '0)) ? t_addr : '0;
    check_field("valid", e_valid, rvfi_valid_o);
    check_field("trap", e_trap, rvfi_trap_o);
    check_field("cause", t_cause, rvfi_cause_o);
    check_field("mode", r_priv, rvfi_mode_o);
    check_field("insn", e_insn, rvfi_insn_o);
    check_field("pc", r_pc, rvfi_pc_o);
    check_field("rs1_addr", r_rs1, rvfi_rs1_addr_o);
    check_field("rs2_addr", r_rs2, rvfi_rs2_addr_o);
    check_field("rd_addr", r_rd, rvfi_rd_addr_o);
    check_field("rs1_rdata", exp_rs1, rvfi_rs1_rdata_o);
    check_field("rs2_rdata", exp_rs2, rvfi_rs2_rdata_o);
    check_field("rd_wdata", t_old, rvfi_rd_wdata_o);
    check_field("mem_addr", exp_addr, rvfi_mem_addr_o);
    check_field("mem_rmask", e_rmask, rvfi_mem_rmask_o);
    check_field("mem_wmask", e_wmask, rvfi_mem_wmask_o);
    check_field("mem_wdata", e_mwdata, rvfi_mem_wdata_o);
    check_field("mem_rdata", r_result, rvfi_mem_rdata_o);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    idle_inputs();
    rst_ni = 1'b0;
    fd = $fopen(InputFile, "r");
    if (fd == 0) begin
      $display("Cannot open the data file %s", InputFile);
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if ((line.len() > 1) && (line[0] != "#")) begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    if (lines.size() == 0) begin
      $display("The data file holds no transactions");
      abort_run();
    end
    cycle_limit = 8 * lines.size() + 50;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (lines[i]) begin
      if (!parse_line(lines[i])) begin
        $display("Data file line cannot be read: %s", lines[i]);
        abort_run();
      end else begin
        run_transaction();
        check_record();
      end
    end
    @(negedge clk_i);
    if (uut.u_chk.err_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", uut.u_chk.err_count);
      abort_run();
    end
  end

endmodule

// File: logic/amo_wdata_calc.sv
// Memory write value of a committed instruction

module amo_wdata_calc
  import isa_pkg::*;
#(
  parameter int unsigned Xlen = 32
) (
  input  commit_op_e      op_i,
  input  logic [Xlen-1:0] mem_old_i,     // Value read from memory, returned to rd
  input  logic [Xlen-1:0] rs2_i,
  input  logic [Xlen-1:0] store_wdata_i,
  output logic [Xlen-1:0] mem_wdata_o
);

  logic            cmp_signed;
  logic [Xlen:0]   cmp_a;
  logic [Xlen:0]   cmp_b;
  logic [Xlen:0]   cmp_diff;
  logic            old_lt_rs2;
  logic [Xlen-1:0] sum;

  // --------------------------------------------------------------------------
  // Shared comparator
  // --------------------------------------------------------------------------

  assign cmp_signed = (op_i == AMO_MAX) || (op_i == AMO_MIN);

  // One extra bit turns both compare flavours into a signed subtraction
  assign cmp_a      = {cmp_signed & mem_old_i[Xlen-1], mem_old_i};
  assign cmp_b      = {cmp_signed & rs2_i[Xlen-1], rs2_i};
  assign cmp_diff   = cmp_a - cmp_b;
  assign old_lt_rs2 = cmp_diff[Xlen]; // Sign of the difference

  assign sum = mem_old_i + rs2_i; // Wraps modulo 2^Xlen

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------

  always_comb begin
    unique case (op_i)
      AMO_SC,
      AMO_SWAP:  mem_wdata_o = rs2_i;
      AMO_ADD:   mem_wdata_o = sum;
      AMO_AND:   mem_wdata_o = mem_old_i & rs2_i;
      AMO_OR:    mem_wdata_o = mem_old_i | rs2_i;
      AMO_XOR:   mem_wdata_o = mem_old_i ^ rs2_i;
      AMO_MAX,
      AMO_MAXU:  mem_wdata_o = old_lt_rs2 ? rs2_i : mem_old_i;
      AMO_MIN,
      AMO_MINU:  mem_wdata_o = old_lt_rs2 ? mem_old_i : rs2_i;
      default:   mem_wdata_o = store_wdata_i; // Plain store, zero for anything else
    endcase
  end

endmodule

// File: logic/isa_pkg.sv
// RISC-V decode definitions

package isa_pkg;

  typedef logic [31:0] instr_t;    // Raw instruction word
  typedef logic [4:0]  reg_addr_t; // Integer register index

  // Privilege levels as encoded in mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Operation class of a committing instruction, only what the tracer tells apart
  typedef enum logic [3:0] {
    OP_OTHER,
    OP_LOAD,
    OP_STORE,
    AMO_SC,
    AMO_SWAP,
    AMO_ADD,
    AMO_AND,
    AMO_OR,
    AMO_XOR,
    AMO_MAX,
    AMO_MIN,
    AMO_MAXU,
    AMO_MINU
  } commit_op_e;

  // Kind of access the load/store unit is working on
  typedef enum logic [1:0] {
    LSU_NONE,
    LSU_LOAD,
    LSU_STORE
  } lsu_fu_e;

  // Environment call exception codes
  localparam int unsigned CauseEcallU = 8;
  localparam int unsigned CauseEcallS = 9;
  localparam int unsigned CauseEcallM = 11;

endpackage

// File: logic/issue_latch.sv
// Fetch-to-issue instruction latch

module issue_latch
  import isa_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   fetch_valid_i,
  input  logic   fetch_compressed_i,
  input  instr_t fetch_instr_i,
  input  logic   issue_ack_i,
  input  logic   flush_i,
  output instr_t instr_o,
  output logic   compressed_o
);

  logic   valid_q;
  logic   load;
  instr_t truncated;
  instr_t instr_q;
  logic   compressed_q;

  // Take a new fetch when the slot is free now or frees up this cycle
  assign load = fetch_valid_i && (!valid_q || issue_ack_i);

  // Only the low half is meaningful for a compressed encoding
  assign truncated = fetch_compressed_i ? {16'b0, fetch_instr_i[15:0]} : fetch_instr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (issue_ack_i) begin
      valid_q <= 1'b0; // Issued, nothing behind it
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_q      <= truncated;
      compressed_q <= fetch_compressed_i;
    end
  end

  assign instr_o      = instr_q;
  assign compressed_o = compressed_q;

endmodule

// File: logic/retire_ctrl.sv
// Retirement record register

module retire_ctrl
  import isa_pkg::*;
#(
  parameter int unsigned Xlen          = 32,
  parameter type         operand_rec_t = logic,
  parameter type         mem_rec_t     = logic
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              commit_valid_i,
  input  logic              commit_ack_i,
  input  logic              commit_drop_i,
  input  logic              ex_valid_i,
  input  logic [Xlen-1:0]   ex_cause_i,
  input  priv_lvl_e         priv_lvl_i,
  input  logic [Xlen-1:0]   commit_pc_i,
  input  logic [Xlen-1:0]   commit_wdata_i,
  input  logic [Xlen-1:0]   commit_result_i,
  input  reg_addr_t         commit_rs1_i,
  input  reg_addr_t         commit_rs2_i,
  input  reg_addr_t         commit_rd_i,
  input  operand_rec_t      op_rec_i,
  input  mem_rec_t          mem_rec_i,
  input  logic [Xlen-1:0]   mem_wdata_i,
  output logic              rvfi_valid_o,
  output logic              rvfi_trap_o,
  output logic [Xlen-1:0]   rvfi_cause_o,
  output priv_lvl_e         rvfi_mode_o,
  output instr_t            rvfi_insn_o,
  output logic [Xlen-1:0]   rvfi_pc_o,
  output reg_addr_t         rvfi_rs1_addr_o,
  output reg_addr_t         rvfi_rs2_addr_o,
  output reg_addr_t         rvfi_rd_addr_o,
  output logic [Xlen-1:0]   rvfi_rs1_rdata_o,
  output logic [Xlen-1:0]   rvfi_rs2_rdata_o,
  output logic [Xlen-1:0]   rvfi_rd_wdata_o,
  output logic [Xlen-1:0]   rvfi_mem_addr_o,
  output logic [Xlen/8-1:0] rvfi_mem_rmask_o,
  output logic [Xlen/8-1:0] rvfi_mem_wmask_o,
  output logic [Xlen-1:0]   rvfi_mem_wdata_o,
  output logic [Xlen-1:0]   rvfi_mem_rdata_o
);

  logic exception;
  logic is_ecall;
  logic valid_d;
  logic trap_d;

  // --------------------------------------------------------------------------
  // Retire decision
  // --------------------------------------------------------------------------

  assign exception = commit_valid_i && ex_valid_i && !commit_drop_i;

  assign is_ecall = (ex_cause_i == Xlen'(CauseEcallU)) ||
                    (ex_cause_i == Xlen'(CauseEcallS)) ||
                    (ex_cause_i == Xlen'(CauseEcallM));

  // An ecall still counts as a retired instruction
  assign valid_d = (commit_ack_i && !ex_valid_i && !commit_drop_i) || (exception && is_ecall);

  // Interrupts set the top cause bit and are not traps of the instruction
  assign trap_d = exception && !ex_cause_i[Xlen-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o <= 1'b0;
      rvfi_trap_o  <= 1'b0;
    end else begin
      rvfi_valid_o <= valid_d;
      rvfi_trap_o  <= trap_d;
    end
  end

  // --------------------------------------------------------------------------
  // Record payload, qualified by valid and trap
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    rvfi_cause_o     <= ex_cause_i;
    rvfi_mode_o      <= priv_lvl_i;
    rvfi_insn_o      <= op_rec_i.instr;
    rvfi_pc_o        <= commit_pc_i;
    rvfi_rs1_addr_o  <= commit_rs1_i;
    rvfi_rs2_addr_o  <= commit_rs2_i;
    rvfi_rd_addr_o   <= commit_rd_i;
    rvfi_rs1_rdata_o <= op_rec_i.rs1_rdata;
    rvfi_rs2_rdata_o <= op_rec_i.rs2_rdata;
    rvfi_rd_wdata_o  <= commit_wdata_i;
    rvfi_mem_addr_o  <= mem_rec_i.addr;
    rvfi_mem_rmask_o <= mem_rec_i.rmask;
    rvfi_mem_wmask_o <= mem_rec_i.wmask;
    rvfi_mem_wdata_o <= mem_wdata_i;     // AMO result or store data
    rvfi_mem_rdata_o <= commit_result_i;
  end

endmodule

// File: logic/rvfi_tracer.sv
// RVFI retirement tracer

module rvfi_tracer
  import isa_pkg::*;
  import trace_pkg::*;
#(
  parameter int unsigned  Xlen        = DefaultXlen,
  parameter int unsigned  NrSbEntries = DefaultSbEntries,
  localparam int unsigned TransIdW    = $clog2(NrSbEntries)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Fetch
  input  logic                 fetch_valid_i,
  input  instr_t               fetch_instr_i,
  input  logic                 fetch_compressed_i,
  input  logic                 issue_ack_i,
  // Issue
  input  logic                 decoded_valid_i,
  input  logic                 decoded_ack_i,
  input  logic                 flush_unissued_i,
  input  logic [TransIdW-1:0]  issue_ptr_i,
  input  logic [Xlen-1:0]      rs1_rdata_i,
  input  logic [Xlen-1:0]      rs2_rdata_i,
  // Load/store unit
  input  lsu_fu_e              lsu_fu_i,
  input  logic [Xlen/8-1:0]    lsu_be_i,
  input  logic [Xlen-1:0]      lsu_vaddr_i,
  input  logic [TransIdW-1:0]  lsu_trans_id_i,
  input  logic [Xlen-1:0]      store_wdata_i,
  // Commit
  input  logic                 commit_valid_i,
  input  logic                 commit_ack_i,
  input  logic                 commit_drop_i,
  input  logic [TransIdW-1:0]  commit_ptr_i,
  input  logic [Xlen-1:0]      commit_pc_i,
  input  commit_op_e           commit_op_i,
  input  reg_addr_t            commit_rs1_i,
  input  reg_addr_t            commit_rs2_i,
  input  reg_addr_t            commit_rd_i,
  input  logic [Xlen-1:0]      commit_wdata_i,
  input  logic [Xlen-1:0]      commit_result_i,
  input  logic                 ex_valid_i,
  input  logic [Xlen-1:0]      ex_cause_i,
  input  priv_lvl_e            priv_lvl_i,
  // Retirement record
  output logic                 rvfi_valid_o,
  output logic                 rvfi_trap_o,
  output logic [Xlen-1:0]      rvfi_cause_o,
  output logic [ModeWidth-1:0] rvfi_mode_o,
  output instr_t               rvfi_insn_o,
  output logic [Xlen-1:0]      rvfi_pc_o,
  output reg_addr_t            rvfi_rs1_addr_o,
  output reg_addr_t            rvfi_rs2_addr_o,
  output reg_addr_t            rvfi_rd_addr_o,
  output logic [Xlen-1:0]      rvfi_rs1_rdata_o,
  output logic [Xlen-1:0]      rvfi_rs2_rdata_o,
  output logic [Xlen-1:0]      rvfi_rd_wdata_o,
  output logic [Xlen-1:0]      rvfi_mem_addr_o,
  output logic [Xlen/8-1:0]    rvfi_mem_rmask_o,
  output logic [Xlen/8-1:0]    rvfi_mem_wmask_o,
  output logic [Xlen-1:0]      rvfi_mem_wdata_o,
  output logic [Xlen-1:0]      rvfi_mem_rdata_o
);

  typedef struct packed {
    logic [Xlen-1:0] rs1_rdata;
    logic [Xlen-1:0] rs2_rdata;
    instr_t          instr;
    logic            compressed;
  } operand_rec_t;

  typedef struct packed {
    logic [Xlen-1:0]   addr;
    logic [Xlen/8-1:0] rmask;
    logic [Xlen/8-1:0] wmask;
    logic [Xlen-1:0]   wdata;
  } mem_rec_t;

  instr_t          latch_instr;
  logic            latch_compressed;
  logic            op_wr;
  operand_rec_t    op_wr_rec;
  operand_rec_t    op_rd_rec;
  logic            lsu_load;
  logic            lsu_store;
  logic            mem_wr;
  mem_rec_t        mem_wr_rec;
  mem_rec_t        mem_rd_rec;
  logic [Xlen-1:0] mem_wdata;

  // --------------------------------------------------------------------------
  // Table write ports
  // --------------------------------------------------------------------------

  assign op_wr     = decoded_valid_i && decoded_ack_i && !flush_unissued_i;
  assign op_wr_rec = '{rs1_rdata: rs1_rdata_i, rs2_rdata: rs2_rdata_i,
                       instr: latch_instr, compressed: latch_compressed};

  assign lsu_load   = (lsu_fu_i == LSU_LOAD);
  assign lsu_store  = (lsu_fu_i == LSU_STORE);
  assign mem_wr     = (lsu_load || lsu_store) && (|lsu_be_i); // Empty byte enable is no access
  assign mem_wr_rec = '{addr:  lsu_vaddr_i,
                        rmask: lsu_load ? lsu_be_i : '0,
                        wmask: lsu_store ? lsu_be_i : '0,
                        wdata: lsu_store ? store_wdata_i : '0};

  issue_latch u_issue_latch (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .fetch_valid_i      (fetch_valid_i),
    .fetch_compressed_i (fetch_compressed_i),
    .fetch_instr_i      (fetch_instr_i),
    .issue_ack_i        (issue_ack_i),
    .flush_i            (flush_i),
    .instr_o            (latch_instr),
    .compressed_o       (latch_compressed)
  );

  trans_table #(
    .NrSbEntries (NrSbEntries),
    .payload_t   (operand_rec_t)
  ) u_operand_table (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (op_wr),
    .wr_idx_i  (issue_ptr_i),
    .wr_data_i (op_wr_rec),
    .clr_i     (commit_valid_i),
    .clr_idx_i (commit_ptr_i),
    .clr_all_i (flush_i),
    .rd_idx_i  (commit_ptr_i),
    .rd_data_o (op_rd_rec)
  );

  trans_table #(
    .NrSbEntries (NrSbEntries),
    .payload_t   (mem_rec_t)
  ) u_mem_table (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wr_i      (mem_wr),
    .wr_idx_i  (lsu_trans_id_i),
    .wr_data_i (mem_wr_rec),
    .clr_i     (commit_valid_i),
    .clr_idx_i (commit_ptr_i),
    .clr_all_i (flush_i),
    .rd_idx_i  (commit_ptr_i),
    .rd_data_o (mem_rd_rec)
  );

  // --------------------------------------------------------------------------
  // Commit side
  // --------------------------------------------------------------------------

  amo_wdata_calc #(
    .Xlen (Xlen)
  ) u_amo_wdata_calc (
    .op_i          (commit_op_i),
    .mem_old_i     (commit_wdata_i), // rd gets the old memory value on an AMO
    .rs2_i         (op_rd_rec.rs2_rdata),
    .store_wdata_i (mem_rd_rec.wdata),
    .mem_wdata_o   (mem_wdata)
  );

  retire_ctrl #(
    .Xlen          (Xlen),
    .operand_rec_t (operand_rec_t),
    .mem_rec_t     (mem_rec_t)
  ) u_retire_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .commit_valid_i   (commit_valid_i),
    .commit_ack_i     (commit_ack_i),
    .commit_drop_i    (commit_drop_i),
    .ex_valid_i       (ex_valid_i),
    .ex_cause_i       (ex_cause_i),
    .priv_lvl_i       (priv_lvl_i),
    .commit_pc_i      (commit_pc_i),
    .commit_wdata_i   (commit_wdata_i),
    .commit_result_i  (commit_result_i),
    .commit_rs1_i     (commit_rs1_i),
    .commit_rs2_i     (commit_rs2_i),
    .commit_rd_i      (commit_rd_i),
    .op_rec_i         (op_rd_rec),
    .mem_rec_i        (mem_rd_rec),
    .mem_wdata_i      (mem_wdata),
    .rvfi_valid_o     (rvfi_valid_o),
    .rvfi_trap_o      (rvfi_trap_o),
    .rvfi_cause_o     (rvfi_cause_o),
    .rvfi_mode_o      (rvfi_mode_o),
    .rvfi_insn_o      (rvfi_insn_o),
    .rvfi_pc_o        (rvfi_pc_o),
    .rvfi_rs1_addr_o  (rvfi_rs1_addr_o),
    .rvfi_rs2_addr_o  (rvfi_rs2_addr_o),
    .rvfi_rd_addr_o   (rvfi_rd_addr_o),
    .rvfi_rs1_rdata_o (rvfi_rs1_rdata_o),
    .rvfi_rs2_rdata_o (rvfi_rs2_rdata_o),
    .rvfi_rd_wdata_o  (rvfi_rd_wdata_o),
    .rvfi_mem_addr_o  (rvfi_mem_addr_o),
    .rvfi_mem_rmask_o (rvfi_mem_rmask_o),
    .rvfi_mem_wmask_o (rvfi_mem_wmask_o),
    .rvfi_mem_wdata_o (rvfi_mem_wdata_o),
    .rvfi_mem_rdata_o (rvfi_mem_rdata_o)
  );

endmodule

// File: logic/trace_pkg.sv
// Tracer configuration

package trace_pkg;

  // --------------------------------------------------------------------------
  // Build defaults
  // --------------------------------------------------------------------------

  localparam int unsigned DefaultXlen      = 32; // 64 is supported as well
  localparam int unsigned DefaultSbEntries = 8;  // Power of two, at least 2

  // --------------------------------------------------------------------------
  // Record field sizes
  // --------------------------------------------------------------------------

  // Privilege mode field of the retirement record
  localparam int unsigned ModeWidth = 2;

endpackage

// File: logic/trans_table.sv
// Per-transaction record table

module trans_table #(
  parameter int unsigned NrSbEntries = 8,
  parameter type         payload_t   = logic,
  localparam int unsigned TransIdW   = $clog2(NrSbEntries)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wr_i,
  input  logic [TransIdW-1:0] wr_idx_i,
  input  payload_t            wr_data_i,
  input  logic                clr_i,
  input  logic [TransIdW-1:0] clr_idx_i,
  input  logic                clr_all_i,
  input  logic [TransIdW-1:0] rd_idx_i,
  output payload_t            rd_data_o
);

  logic     [NrSbEntries-1:0] valid_q;
  payload_t                   data_q [NrSbEntries];

  // Valid bits, a write beats any clear hitting the same entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NrSbEntries; i++) begin
        if (wr_i && (wr_idx_i == TransIdW'(i))) begin
          valid_q[i] <= 1'b1;
        end else if (clr_all_i || (clr_i && (clr_idx_i == TransIdW'(i)))) begin
          valid_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      data_q[wr_idx_i] <= wr_data_i; // Whole entry replaced
    end
  end

  // Stale payload is hidden behind the valid bit
  assign rd_data_o = valid_q[rd_idx_i] ? data_q[rd_idx_i] : '0;

endmodule

// File: sources.f
logic/isa_pkg.sv
logic/trace_pkg.sv
logic/issue_latch.sv
logic/trans_table.sv
logic/amo_wdata_calc.sv
logic/retire_ctrl.sv
logic/rvfi_tracer.sv
dv/rvfi_tracer_chk.sv
dv/tb_rvfi_tracer.sv
